//--- pool_data_pkg.sv
`default_nettype none

package pool_data_pkg;

	// Lane word
	localparam int WORD_W = 16;

	// Largest window exponent, windows of up to 16 atoms
	localparam int MAX_WIN_LOG2 = 4;

	// Room for the sum of a full window of words
	localparam int ACC_W = WORD_W + MAX_WIN_LOG2;

	// Enough bits to hold 0 to MAX_WIN_LOG2
	localparam int WIN_LOG2_W = 3;

	typedef logic signed [WORD_W-1:0] word_t;     // One lane value
	typedef logic signed [ACC_W-1:0]  acc_t;      // Lane running sum
	typedef logic [WIN_LOG2_W-1:0]    win_log2_t; // Window size as a power of two

endpackage

`default_nettype wire

//--- pool_ctrl_pkg.sv
`default_nettype none

package pool_ctrl_pkg;

	import pool_data_pkg::*;

	// Reduction applied across the window
	typedef enum logic {
		OP_MAX = 1'b0, // Signed maximum per lane
		OP_AVG = 1'b1  // Sum shifted right by win_log2
	} pool_op_e;

	// Command word, held stable while req is high
	typedef struct packed {
		pool_op_e  op;
		win_log2_t win_log2;
	} pool_cmd_t;

	// Sequencer FSM
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0, // Waiting for req
		ST_READ  = 3'd1, // Read open, counting atoms
		ST_DRAIN = 3'd2, // Lane results being registered
		ST_WRITE = 3'd3, // Write-back in progress
		ST_ACK   = 3'd4  // Ack high until req drops
	} seq_state_e;

endpackage

`default_nettype wire

//--- atom_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module atom_deserializer
	import pool_data_pkg::*;
#(
	parameter int BURST_LEN = 8
)(
	input  logic  clk,
	input  logic  rst,
	input  logic  i_take,                // Read enable from the sequencer
	input  logic  i_in_we,               // Write strobe from the source
	input  word_t i_in_data,
	output logic  o_atom_valid,          // One-cycle pulse per full atom
	output word_t o_atom [BURST_LEN]
);

	localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

	logic [CNT_W-1:0] burst_cnt; // Words gathered into the current atom
	logic             accept;    // Strobe that counts
	logic             last_word;

	assign accept    = i_take && i_in_we; // Strobes outside the read window are dropped
	assign last_word = (burst_cnt == CNT_W'(BURST_LEN - 1));

	// Burst counter and atom flag
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			burst_cnt    <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= 1'b0;
			if (!i_take) begin
				burst_cnt <= '0; // Partial atom discarded once read closes
			end else if (accept) begin
				if (last_word) begin
					burst_cnt    <= '0;
					o_atom_valid <= 1'b1; // Atom complete, flag next cycle
				end else begin
					burst_cnt <= burst_cnt + 1'b1;
				end
			end
		end
	end

	// Shift register, newest word enters the top lane
	// After BURST_LEN shifts the first word sits in lane 0
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int i = 0; i < BURST_LEN - 1; i++) begin
				o_atom[i] <= o_atom[i+1];
			end
			o_atom[BURST_LEN-1] <= i_in_data;
		end
	end

endmodule

`default_nettype wire

//--- lane_pool_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lane_pool_unit
	import pool_data_pkg::*;
	import pool_ctrl_pkg::*;
#(
	parameter int BURST_LEN = 8
)(
	input  logic      clk,
	input  logic      rst,
	input  logic      i_atom_valid,
	input  word_t     i_atom [BURST_LEN],
	input  logic      i_win_start,   // Atom opens the window
	input  logic      i_win_last,    // Atom closes the window
	input  pool_op_e  i_op,
	input  win_log2_t i_win_log2,
	output logic      o_result_valid,
	output word_t     o_result [BURST_LEN]
);

	word_t max_q   [BURST_LEN]; // Running maximum per lane
	acc_t  sum_q   [BURST_LEN]; // Running sum per lane
	word_t max_nxt [BURST_LEN];
	acc_t  sum_nxt [BURST_LEN];
	acc_t  avg_nxt [BURST_LEN]; // Sum scaled down by the window size

	// Fold the incoming atom into each lane
	always_comb begin
		for (int i = 0; i < BURST_LEN; i++) begin
			if (i_win_start) begin
				max_nxt[i] = i_atom[i];        // First atom seeds both
				sum_nxt[i] = acc_t'(i_atom[i]); // Sign extended
			end else begin
				max_nxt[i] = (i_atom[i] > max_q[i]) ? i_atom[i] : max_q[i]; // Signed compare
				sum_nxt[i] = sum_q[i] + acc_t'(i_atom[i]);
			end
			// Arithmetic shift, rounds toward minus infinity
			avg_nxt[i] = sum_nxt[i] >>> i_win_log2;
		end
	end

	// Lane state and results
	always_ff @(posedge clk) begin
		if (i_atom_valid) begin
			for (int i = 0; i < BURST_LEN; i++) begin
				max_q[i] <= max_nxt[i];
				sum_q[i] <= sum_nxt[i];
				if (i_win_last) begin
					// Average of words always fits back in a word
					o_result[i] <= (i_op == OP_MAX) ? max_nxt[i] : word_t'(avg_nxt[i]);
				end
			end
		end
	end

	// Result flag, one cycle after the closing atom
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_result_valid <= 1'b0;
		else
			o_result_valid <= i_atom_valid && i_win_last;
	end

endmodule

`default_nettype wire

//--- result_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module result_serializer
	import pool_data_pkg::*;
#(
	parameter int BURST_LEN = 8
)(
	input  logic  clk,
	input  logic  rst,
	input  logic  i_result_valid,
	input  word_t i_result [BURST_LEN],
	output logic  o_wr_en,           // High for BURST_LEN cycles
	output word_t o_wr_data,
	output logic  o_wr_done          // With the last word
);

	localparam int IDX_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

	word_t            res_buf [BURST_LEN]; // Latched lane results
	logic [IDX_W-1:0] lane_idx;            // Lane on the write port
	logic             last_lane;

	assign last_lane = (lane_idx == IDX_W'(BURST_LEN - 1));

	// Write window and lane stepping
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_wr_en  <= 1'b0;
			lane_idx <= '0;
		end else if (i_result_valid) begin
			o_wr_en  <= 1'b1; // Lane 0 goes out next cycle
			lane_idx <= '0;
		end else if (o_wr_en) begin
			if (last_lane) begin
				o_wr_en  <= 1'b0;
				lane_idx <= '0;
			end else begin
				lane_idx <= lane_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_result_valid)
			res_buf <= i_result;
	end

	assign o_wr_data = res_buf[lane_idx];
	assign o_wr_done = o_wr_en && last_lane; // No back-pressure, so last word is done

endmodule

`default_nettype wire

//--- pool_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pool_sequencer
	import pool_data_pkg::*;
	import pool_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      i_cmd_req,
	input  pool_cmd_t i_cmd,
	output logic      o_cmd_ack,
	output logic      o_rd_en,      // Also the deserializer take enable
	input  logic      i_atom_valid,
	output logic      o_win_start,
	output logic      o_win_last,
	output pool_op_e  o_op,
	output win_log2_t o_win_log2,
	input  logic      i_wr_done
);

	localparam int CNT_W = MAX_WIN_LOG2 + 1;

	seq_state_e       state;
	pool_cmd_t        cmd_q;    // Command sampled on accept
	logic [CNT_W-1:0] atom_cnt; // Atoms folded so far in this window
	logic [CNT_W-1:0] win_len;  // Atoms per window

	assign win_len = CNT_W'(1) << cmd_q.win_log2;

	assign o_win_start = (atom_cnt == '0);
	assign o_win_last  = (atom_cnt == win_len - 1'b1);
	assign o_op        = cmd_q.op;
	assign o_win_log2  = cmd_q.win_log2;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= ST_IDLE;
			cmd_q     <= '0;
			atom_cnt  <= '0;
			o_rd_en   <= 1'b0;
			o_cmd_ack <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_cmd_req) begin // Ack is already low here
						cmd_q    <= i_cmd;
						atom_cnt <= '0;
						o_rd_en  <= 1'b1;
						state    <= ST_READ;
					end
				end
				ST_READ: begin
					if (i_atom_valid) begin
						if (o_win_last) begin
							o_rd_en <= 1'b0; // Window complete, close read
							state   <= ST_DRAIN;
						end else begin
							atom_cnt <= atom_cnt + 1'b1;
						end
					end
				end
				ST_DRAIN: begin
					state <= ST_WRITE; // Lane results valid this cycle
				end
				ST_WRITE: begin
					if (i_wr_done) begin
						o_cmd_ack <= 1'b1;
						state     <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!i_cmd_req) begin // Four-phase return to zero
						o_cmd_ack <= 1'b0;
						state     <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- pool_engine.sv
`timescale 1ns/1ps
`default_nettype none

module pool_engine
	import pool_data_pkg::*;
	import pool_ctrl_pkg::*;
#(
	parameter int BURST_LEN = 8 // Lanes per atom, 4, 8 or 16
)(
	input  logic      clk,
	input  logic      rst,
	input  logic      i_cmd_req,
	input  pool_cmd_t i_cmd,
	output logic      o_cmd_ack,
	output logic      o_rd_en,
	input  logic      i_in_we,
	input  word_t     i_in_data,
	output logic      o_wr_en,
	output word_t     o_wr_data
);

	logic      atom_valid;
	word_t     atom [BURST_LEN];
	logic      win_start;
	logic      win_last;
	pool_op_e  op;
	win_log2_t win_log2;
	logic      result_valid;
	word_t     result [BURST_LEN];
	logic      wr_done;

	pool_sequencer pool_sequencer_i (
		.clk          (clk),
		.rst          (rst),
		.i_cmd_req    (i_cmd_req),
		.i_cmd        (i_cmd),
		.o_cmd_ack    (o_cmd_ack),
		.o_rd_en      (o_rd_en),
		.i_atom_valid (atom_valid),
		.o_win_start  (win_start),
		.o_win_last   (win_last),
		.o_op         (op),
		.o_win_log2   (win_log2),
		.i_wr_done    (wr_done)
	);

	// Read enable doubles as the take enable
	atom_deserializer #(.BURST_LEN(BURST_LEN)) atom_deserializer_i (
		.clk          (clk),
		.rst          (rst),
		.i_take       (o_rd_en),
		.i_in_we      (i_in_we),
		.i_in_data    (i_in_data),
		.o_atom_valid (atom_valid),
		.o_atom       (atom)
	);

	lane_pool_unit #(.BURST_LEN(BURST_LEN)) lane_pool_unit_i (
		.clk            (clk),
		.rst            (rst),
		.i_atom_valid   (atom_valid),
		.i_atom         (atom),
		.i_win_start    (win_start),
		.i_win_last     (win_last),
		.i_op           (op),
		.i_win_log2     (win_log2),
		.o_result_valid (result_valid),
		.o_result       (result)
	);

	result_serializer #(.BURST_LEN(BURST_LEN)) result_serializer_i (
		.clk            (clk),
		.rst            (rst),
		.i_result_valid (result_valid),
		.i_result       (result),
		.o_wr_en        (o_wr_en),
		.o_wr_data      (o_wr_data),
		.o_wr_done      (wr_done)
	);

endmodule

`default_nettype wire

//--- pool_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pool_engine_tb
	import pool_data_pkg::*;
	import pool_ctrl_pkg::*;
();

	localparam int BURST_LEN = 8;
	localparam int N_CMDS    = 9;   // Commands issued by the main sequence

	logic        clk;
	logic        rst;
	logic        i_cmd_req;
	pool_cmd_t   i_cmd;
	logic        o_cmd_ack;
	logic        o_rd_en;
	logic        i_in_we;
	word_t       i_in_data;
	logic        o_wr_en;
	word_t       o_wr_data;

	logic [31:0] rng;          // Xorshift state
	int          errors;
	int          cmd_count;
	int          run_len;      // Length of the current write burst
	word_t       got_q [$];    // Words seen on the write port

	pool_engine #(.BURST_LEN(BURST_LEN)) pool_engine_i (
		.clk       (clk),
		.rst       (rst),
		.i_cmd_req (i_cmd_req),
		.i_cmd     (i_cmd),
		.o_cmd_ack (o_cmd_ack),
		.o_rd_en   (o_rd_en),
		.i_in_we   (i_in_we),
		.i_in_data (i_in_data),
		.o_wr_en   (o_wr_en),
		.o_wr_data (o_wr_data)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Write port collector, also checks burst framing
	always @(posedge clk) begin
		if (rst) begin
			run_len = 0;
		end else if (o_wr_en) begin
			got_q.push_back(o_wr_data);
			run_len++;
		end else if (run_len != 0) begin
			assert (run_len == BURST_LEN) else begin
				errors++;
				$display("write burst of %0d words, expected %0d", run_len, BURST_LEN);
			end
			run_len = 0;
		end
	end

	// Write only inside an open command, before ack
	assert property (@(posedge clk) disable iff (rst) o_wr_en |-> (i_cmd_req && !o_cmd_ack))
		else begin
			errors++;
			$display("write enable high outside an active command");
		end

	// Read only while a command is being served
	assert property (@(posedge clk) disable iff (rst) o_rd_en |-> (i_cmd_req && !o_cmd_ack))
		else begin
			errors++;
			$display("read enable high between commands");
		end

	assert property (@(posedge clk) disable iff (rst) $rose(o_cmd_ack) |-> i_cmd_req)
		else begin
			errors++;
			$display("ack rose while req was low");
		end

	assert property (@(posedge clk) disable iff (rst) $fell(o_cmd_ack) |-> !i_cmd_req)
		else begin
			errors++;
			$display("ack fell before req was dropped");
		end

	// One command: junk strobes, feed a window of words, check the lane results
	task automatic run_cmd(input string name, input pool_op_e op, input int wl, input bit neg);
		int    n_words;
		int    sent;
		int    lane;
		int    i;
		int    exp_val;
		word_t w;
		int    lane_max [BURST_LEN];
		int    lane_sum [BURST_LEN];
		n_words = BURST_LEN << wl;
		sent    = 0;
		got_q.delete();
		repeat (3) begin // Read still closed, must be ignored
			@(posedge clk);
			rng = xorshift(rng);
			i_in_we   <= 1'b1;
			i_in_data <= word_t'(rng[15:0]);
		end
		@(posedge clk);
		i_in_we   <= 1'b0;
		i_cmd_req <= 1'b1;
		i_cmd     <= '{op: op, win_log2: win_log2_t'(wl)};
		while (!o_cmd_ack) begin
			@(posedge clk);
			rng = xorshift(rng);
			if (o_rd_en && sent < n_words && (rng % 32'd3) != 32'd0) begin
				w    = neg ? word_t'({1'b1, rng[30:16]}) : word_t'(rng[31:16]);
				lane = sent % BURST_LEN; // First word of an atom is lane 0
				if (sent < BURST_LEN) begin
					lane_max[lane] = int'(w);
					lane_sum[lane] = int'(w);
				end else begin
					if (int'(w) > lane_max[lane])
						lane_max[lane] = int'(w);
					lane_sum[lane] += int'(w);
				end
				i_in_we   <= 1'b1;
				i_in_data <= w;
				sent++;
			end else if (sent == n_words && !o_rd_en) begin
				i_in_we   <= rng[4];              // Junk after the last atom
				i_in_data <= word_t'(rng[20:5]);
			end else begin
				i_in_we <= 1'b0;                  // Gap
			end
		end
		i_in_we <= 1'b0;
		rng = xorshift(rng);
		repeat (int'(rng[1:0])) @(posedge clk); // Req lingers past ack for a few cycles
		i_cmd_req <= 1'b0;
		while (o_cmd_ack)
			@(posedge clk);
		assert (got_q.size() == BURST_LEN) else begin
			errors++;
			$display("** Error: %s write words expected %0d actual %0d",
				name, BURST_LEN, got_q.size());
		end
		for (i = 0; i < BURST_LEN && i < got_q.size(); i++) begin
			// Average rounds toward minus infinity
			exp_val = (op == OP_MAX) ? lane_max[i] : (lane_sum[i] >>> wl);
			assert (got_q[i] == word_t'(exp_val)) else begin
				errors++;
				$display("** Error: %s lane %0d expected %0d actual %0d",
					name, i, word_t'(exp_val), got_q[i]);
			end
		end
		cmd_count++;
	endtask

	// Watchdog
	initial begin
		repeat (16 + 200 * N_CMDS) @(posedge clk);
		$display("timeout: commands did not complete within %0d cycles", 16 + 200 * N_CMDS);
		$display("sim failed");
		$finish;
	end

	initial begin
		rng       = 32'h1a35;
		errors    = 0;
		cmd_count = 0;
		run_len   = 0;
		rst       = 1'b1;
		i_cmd_req = 1'b0;
		i_cmd     = '0;
		i_in_we   = 1'b0;
		i_in_data = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		assert (!o_cmd_ack && !o_rd_en && !o_wr_en) else begin
			errors++;
			$display("ack, read or write enable not low after reset");
		end
		run_cmd("max_w1", OP_MAX, 1, 1'b0);
		run_cmd("max_w2", OP_MAX, 2, 1'b0);
		run_cmd("max_w4", OP_MAX, 4, 1'b0);
		run_cmd("avg_w2", OP_AVG, 2, 1'b0);   // Op changes back to back
		run_cmd("avg_w4_neg", OP_AVG, 4, 1'b1);
		run_cmd("avg_w2_neg", OP_AVG, 2, 1'b1);
		run_cmd("max_w0", OP_MAX, 0, 1'b0);   // Single atom passes through
		run_cmd("avg_w0", OP_AVG, 0, 1'b0);
		run_cmd("avg_w4", OP_AVG, 4, 1'b0);
		repeat (4) @(posedge clk);
		$display("errors: %0d over %0d commands", errors, cmd_count);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
pool_data_pkg.sv
pool_ctrl_pkg.sv
atom_deserializer.sv
lane_pool_unit.sv
result_serializer.sv
pool_sequencer.sv
pool_engine.sv
pool_engine_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the pooling engine testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module pool_engine_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vpool_engine_tb)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
